/* source/bridge_pkg.sv */
package bridge_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;  // axi data bus
  localparam int LINE_BEATS = 4;
  localparam int LINE_W     = DATA_W * LINE_BEATS;  // one cache line

  // access type as the cpu side encodes it
  typedef enum logic [2:0] {
    ACC_BYTE = 3'b000,
    ACC_HALF = 3'b001,
    ACC_WORD = 3'b010,
    ACC_LINE = 3'b100
  } access_e;

  typedef struct packed {
    logic              req;
    access_e           rtype;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic              wr;
    access_e           wtype;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        wstrb;  // same strobe on every beat of a line
    logic [LINE_W-1:0] wdata;
  } wr_req_t;

  typedef struct packed {
    logic              rready;  // request accepted
    logic              rvalid;
    logic              rlast;
    logic              wready;
    logic [DATA_W-1:0] rdata;
  } port_rsp_t;

  // shared by the AR and AW channels
  typedef struct packed {
    logic [3:0]        id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
  } axi_cmd_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR_DATA, WR_RESP} wr_state_e;

endpackage

/* source/bridge_req_decode.sv */
module bridge_req_decode #(
  parameter logic [3:0] INST_ARID = 4'd0,
  parameter logic [3:0] DATA_ARID = 4'd1
) (
  input  logic                          clk,
  input  logic                          mw_addr_finish_rst,
  input  bridge_pkg::rd_req_t           inst_req_i,
  input  bridge_pkg::rd_req_t           data_req_i,
  input  bridge_pkg::wr_req_t           data_wr_i,
  input  logic                          rd_busy_i,
  input  logic                          wr_busy_i,
  output logic                          inst_rready_o,
  output logic                          data_rready_o,
  output logic                          data_wready_o,
  output logic                          rd_start_o,
  output logic                          wr_start_o,
  output bridge_pkg::axi_cmd_t          ar_cmd_o,
  output bridge_pkg::axi_cmd_t          aw_cmd_o,
  output logic [3:0]                    wstrb_o,
  output logic [bridge_pkg::LINE_W-1:0] wline_o,
  output logic                          line_write_o
);

  logic                 engines_idle;
  logic                 inst_acc;
  logic                 data_rd_acc;
  logic                 wr_acc;
  bridge_pkg::axi_cmd_t ar_cmd_q;
  bridge_pkg::axi_cmd_t aw_cmd_q;

  // access type to burst length and beat size
  function automatic bridge_pkg::axi_cmd_t make_cmd(
    input logic [3:0]                    id,
    input logic [bridge_pkg::ADDR_W-1:0] addr,
    input bridge_pkg::access_e           acc
  );
    bridge_pkg::axi_cmd_t cmd;
    cmd.id   = id;
    cmd.addr = addr;
    cmd.len  = 8'd0;
    case (acc)
      bridge_pkg::ACC_BYTE: cmd.size = 3'd0;
      bridge_pkg::ACC_HALF: cmd.size = 3'd1;
      bridge_pkg::ACC_LINE: begin
        cmd.len  = 8'(bridge_pkg::LINE_BEATS - 1);  // 4 beat incr burst
        cmd.size = 3'd2;
      end
      default: cmd.size = 3'd2;  // word, and any unknown code
    endcase
    return cmd;
  endfunction

  // priority: data write, data read, instruction read
  assign engines_idle  = !rd_busy_i && !wr_busy_i;
  assign data_wready_o = engines_idle;
  assign data_rready_o = engines_idle && !data_wr_i.wr;
  assign inst_rready_o = engines_idle && !data_wr_i.wr && !data_req_i.req;

  assign wr_acc      = data_wr_i.wr && data_wready_o;
  assign data_rd_acc = data_req_i.req && data_rready_o;
  assign inst_acc    = inst_req_i.req && inst_rready_o;

  assign rd_start_o = data_rd_acc || inst_acc;
  assign wr_start_o = wr_acc;

  always_ff @(posedge clk) begin
    if (mw_addr_finish_rst) begin
      ar_cmd_q <= '0;
      aw_cmd_q <= '0;
    end else begin
      if (data_rd_acc) begin
        ar_cmd_q <= make_cmd(DATA_ARID, data_req_i.addr, data_req_i.rtype);
      end else if (inst_acc) begin
        ar_cmd_q <= make_cmd(INST_ARID, inst_req_i.addr, inst_req_i.rtype);
      end
      if (wr_acc) begin
        aw_cmd_q <= make_cmd(DATA_ARID, data_wr_i.addr, data_wr_i.wtype);  // len from wtype
      end
    end
  end

  assign ar_cmd_o = ar_cmd_q;
  assign aw_cmd_o = aw_cmd_q;

  // write payload, latched by the write engine at wr_start
  assign wstrb_o      = data_wr_i.wstrb;
  assign wline_o      = data_wr_i.wdata;
  assign line_write_o = (data_wr_i.wtype == bridge_pkg::ACC_LINE);

endmodule

/* source/bridge_read_engine.sv */
module bridge_read_engine #(
  parameter logic [3:0] DATA_ARID = 4'd1
) (
  input  logic                          clk,
  input  logic                          mw_addr_finish_rst,
  input  logic                          rd_start_i,
  input  bridge_pkg::axi_cmd_t          ar_cmd_i,
  input  logic                          m_arready_i,
  input  logic [3:0]                    m_rid_i,
  input  logic [bridge_pkg::DATA_W-1:0] m_rdata_i,
  input  logic                          m_rlast_i,
  input  logic                          m_rvalid_i,
  output logic                          m_arvalid_o,
  output bridge_pkg::axi_cmd_t          m_ar_o,
  output logic                          m_rready_o,
  output logic                          rd_busy_o,
  output bridge_pkg::port_rsp_t         inst_rsp_o,
  output bridge_pkg::port_rsp_t         data_rsp_o
);

  bridge_pkg::rd_state_e state_q;
  bridge_pkg::rd_state_e state_d;
  logic                  beat;     // accepted R beat
  logic                  to_data;

  always_comb begin
    state_d = state_q;
    case (state_q)
      bridge_pkg::RD_IDLE: begin
        if (rd_start_i) begin
          state_d = bridge_pkg::RD_ADDR;
        end
      end
      bridge_pkg::RD_ADDR: begin
        if (m_arready_i) begin
          state_d = bridge_pkg::RD_DATA;
        end
      end
      bridge_pkg::RD_DATA: begin
        if (m_rvalid_i && m_rlast_i) begin
          state_d = bridge_pkg::RD_IDLE;
        end
      end
      default: state_d = bridge_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mw_addr_finish_rst) begin
      state_q <= bridge_pkg::RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign m_arvalid_o = (state_q == bridge_pkg::RD_ADDR);
  assign m_ar_o      = ar_cmd_i;  // held by decode until the next accept
  assign m_rready_o  = (state_q == bridge_pkg::RD_DATA);
  assign rd_busy_o   = (state_q != bridge_pkg::RD_IDLE);

  // steer by id, anything not the data id goes to port 1
  assign beat    = m_rready_o && m_rvalid_i;
  assign to_data = (m_rid_i == DATA_ARID);

  assign data_rsp_o.rready = 1'b0;  // filled in at the top
  assign data_rsp_o.wready = 1'b0;
  assign data_rsp_o.rvalid = beat && to_data;
  assign data_rsp_o.rlast  = beat && to_data && m_rlast_i;
  assign data_rsp_o.rdata  = m_rdata_i;

  assign inst_rsp_o.rready = 1'b0;
  assign inst_rsp_o.wready = 1'b0;
  assign inst_rsp_o.rvalid = beat && !to_data;
  assign inst_rsp_o.rlast  = beat && !to_data && m_rlast_i;
  assign inst_rsp_o.rdata  = m_rdata_i;

endmodule

/* source/bridge_write_engine.sv */
module bridge_write_engine (
  input  logic                          clk,
  input  logic                          mw_addr_finish_rst,
  input  logic                          wr_start_i,
  input  bridge_pkg::axi_cmd_t          aw_cmd_i,
  input  logic [3:0]                    wstrb_i,
  input  logic [bridge_pkg::LINE_W-1:0] wline_i,
  input  logic                          line_write_i,
  input  logic                          m_awready_i,
  input  logic                          m_wready_i,
  input  logic                          m_bvalid_i,
  output logic                          m_awvalid_o,
  output bridge_pkg::axi_cmd_t          m_aw_o,
  output logic                          m_wvalid_o,
  output logic [bridge_pkg::DATA_W-1:0] m_wdata_o,
  output logic [3:0]                    m_wstrb_o,
  output logic                          m_wlast_o,
  output logic                          m_bready_o,
  output logic                          wr_busy_o
);

  localparam int CNT_W = $clog2(bridge_pkg::LINE_BEATS);

  bridge_pkg::wr_state_e         state_q;
  bridge_pkg::wr_state_e         state_d;
  logic [CNT_W-1:0]              cnt_q;      // beats left after the current one
  logic [CNT_W-1:0]              beat_idx;
  logic                          aw_done;
  logic                          w_done;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          w_last_hs;
  logic [bridge_pkg::LINE_W-1:0] line_q;
  logic [3:0]                    strb_q;
  logic                          line_wr_q;

  assign aw_hs     = m_awvalid_o && m_awready_i;
  assign w_hs      = m_wvalid_o && m_wready_i;
  assign w_last_hs = w_hs && (cnt_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      bridge_pkg::WR_IDLE: begin
        if (wr_start_i) begin
          state_d = bridge_pkg::WR_ADDR_DATA;
        end
      end
      bridge_pkg::WR_ADDR_DATA: begin
        // AW and W finish in any order
        if ((aw_done || aw_hs) && (w_done || w_last_hs)) begin
          state_d = bridge_pkg::WR_RESP;
        end
      end
      bridge_pkg::WR_RESP: begin
        if (m_bvalid_i) begin
          state_d = bridge_pkg::WR_IDLE;
        end
      end
      default: state_d = bridge_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mw_addr_finish_rst) begin
      state_q <= bridge_pkg::WR_IDLE;
      cnt_q   <= '0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_start_i) begin
        cnt_q   <= line_write_i ? CNT_W'(bridge_pkg::LINE_BEATS - 1) : '0;
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end else begin
        if (aw_hs) begin
          aw_done <= 1'b1;
        end
        if (w_hs) begin
          if (cnt_q == '0) begin
            w_done <= 1'b1;
          end else begin
            cnt_q <= cnt_q - CNT_W'(1);
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start_i) begin
      line_q    <= wline_i;
      strb_q    <= wstrb_i;
      line_wr_q <= line_write_i;
    end
  end

  // lowest word goes out first
  assign beat_idx = line_wr_q ? CNT_W'(bridge_pkg::LINE_BEATS - 1) - cnt_q : '0;

  assign m_awvalid_o = (state_q == bridge_pkg::WR_ADDR_DATA) && !aw_done;
  assign m_wvalid_o  = (state_q == bridge_pkg::WR_ADDR_DATA) && !w_done;
  assign m_aw_o      = aw_cmd_i;
  assign m_wdata_o   = line_q[beat_idx*bridge_pkg::DATA_W +: bridge_pkg::DATA_W];
  assign m_wstrb_o   = strb_q;
  assign m_wlast_o   = m_wvalid_o && (cnt_q == '0);
  assign m_bready_o  = (state_q == bridge_pkg::WR_RESP);
  assign wr_busy_o   = (state_q != bridge_pkg::WR_IDLE);

endmodule

/* source/sram_axi_bridge.sv */
module sram_axi_bridge #(
  parameter logic [3:0] INST_ARID = 4'd0,
  parameter logic [3:0] DATA_ARID = 4'd1
) (
  input  logic                          clk,
  input  logic                          mw_addr_finish_rst,
  // cpu ports
  input  bridge_pkg::rd_req_t           inst_req_i,
  input  bridge_pkg::rd_req_t           data_req_i,
  input  bridge_pkg::wr_req_t           data_wr_i,
  output bridge_pkg::port_rsp_t         inst_rsp_o,
  output bridge_pkg::port_rsp_t         data_rsp_o,
  // axi read
  output logic [3:0]                    m_arid_o,
  output logic [bridge_pkg::ADDR_W-1:0] m_araddr_o,
  output logic [7:0]                    m_arlen_o,
  output logic [2:0]                    m_arsize_o,
  output logic                          m_arvalid_o,
  input  logic                          m_arready_i,
  input  logic [3:0]                    m_rid_i,
  input  logic [bridge_pkg::DATA_W-1:0] m_rdata_i,
  input  logic                          m_rlast_i,
  input  logic                          m_rvalid_i,
  output logic                          m_rready_o,
  // axi write
  output logic [bridge_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic [7:0]                    m_awlen_o,
  output logic [2:0]                    m_awsize_o,
  output logic                          m_awvalid_o,
  input  logic                          m_awready_i,
  output logic [bridge_pkg::DATA_W-1:0] m_wdata_o,
  output logic [3:0]                    m_wstrb_o,
  output logic                          m_wlast_o,
  output logic                          m_wvalid_o,
  input  logic                          m_wready_i,
  input  logic                          m_bvalid_i,
  output logic                          m_bready_o
);

  logic                          inst_rready;
  logic                          data_rready;
  logic                          data_wready;
  logic                          rd_start;
  logic                          wr_start;
  logic                          rd_busy;
  logic                          wr_busy;
  logic [3:0]                    wstrb;
  logic [bridge_pkg::LINE_W-1:0] wline;
  logic                          line_write;
  bridge_pkg::axi_cmd_t          ar_cmd;
  bridge_pkg::axi_cmd_t          aw_cmd;
  bridge_pkg::axi_cmd_t          m_ar;
  bridge_pkg::axi_cmd_t          m_aw;
  bridge_pkg::port_rsp_t         inst_rd_rsp;
  bridge_pkg::port_rsp_t         data_rd_rsp;

  bridge_req_decode #(
    .INST_ARID (INST_ARID),
    .DATA_ARID (DATA_ARID)
  ) i_decode (
    .clk                (clk),
    .mw_addr_finish_rst (mw_addr_finish_rst),
    .inst_req_i         (inst_req_i),
    .data_req_i         (data_req_i),
    .data_wr_i          (data_wr_i),
    .rd_busy_i          (rd_busy),
    .wr_busy_i          (wr_busy),
    .inst_rready_o      (inst_rready),
    .data_rready_o      (data_rready),
    .data_wready_o      (data_wready),
    .rd_start_o         (rd_start),
    .wr_start_o         (wr_start),
    .ar_cmd_o           (ar_cmd),
    .aw_cmd_o           (aw_cmd),
    .wstrb_o            (wstrb),
    .wline_o            (wline),
    .line_write_o       (line_write)
  );

  bridge_read_engine #(
    .DATA_ARID (DATA_ARID)
  ) i_read (
    .clk                (clk),
    .mw_addr_finish_rst (mw_addr_finish_rst),
    .rd_start_i         (rd_start),
    .ar_cmd_i           (ar_cmd),
    .m_arready_i        (m_arready_i),
    .m_rid_i            (m_rid_i),
    .m_rdata_i          (m_rdata_i),
    .m_rlast_i          (m_rlast_i),
    .m_rvalid_i         (m_rvalid_i),
    .m_arvalid_o        (m_arvalid_o),
    .m_ar_o             (m_ar),
    .m_rready_o         (m_rready_o),
    .rd_busy_o          (rd_busy),
    .inst_rsp_o         (inst_rd_rsp),
    .data_rsp_o         (data_rd_rsp)
  );

  bridge_write_engine i_write (
    .clk                (clk),
    .mw_addr_finish_rst (mw_addr_finish_rst),
    .wr_start_i         (wr_start),
    .aw_cmd_i           (aw_cmd),
    .wstrb_i            (wstrb),
    .wline_i            (wline),
    .line_write_i       (line_write),
    .m_awready_i        (m_awready_i),
    .m_wready_i         (m_wready_i),
    .m_bvalid_i         (m_bvalid_i),
    .m_awvalid_o        (m_awvalid_o),
    .m_aw_o             (m_aw),
    .m_wvalid_o         (m_wvalid_o),
    .m_wdata_o          (m_wdata_o),
    .m_wstrb_o          (m_wstrb_o),
    .m_wlast_o          (m_wlast_o),
    .m_bready_o         (m_bready_o),
    .wr_busy_o          (wr_busy)
  );

  assign m_arid_o   = m_ar.id;
  assign m_araddr_o = m_ar.addr;
  assign m_arlen_o  = m_ar.len;
  assign m_arsize_o = m_ar.size;
  assign m_awaddr_o = m_aw.addr;  // no awid, writes use a fixed id
  assign m_awlen_o  = m_aw.len;
  assign m_awsize_o = m_aw.size;

  // port 1 never writes
  assign inst_rsp_o = '{rready: inst_rready, rvalid: inst_rd_rsp.rvalid,
                        rlast: inst_rd_rsp.rlast, wready: 1'b0,
                        rdata: inst_rd_rsp.rdata};
  assign data_rsp_o = '{rready: data_rready, rvalid: data_rd_rsp.rvalid,
                        rlast: data_rd_rsp.rlast, wready: data_wready,
                        rdata: data_rd_rsp.rdata};

endmodule

/* test/bridge_assertions.sv */
module bridge_assertions (
  input logic                 clk,
  input logic                 rst_i,
  input logic                 awvalid_i,
  input logic                 awready_i,
  input logic                 wvalid_i,
  input logic                 wready_i,
  input logic                 wlast_i,
  input bridge_pkg::axi_cmd_t aw_i
);

  logic [7:0] w_beats;  // W beats taken in the current burst

  always_ff @(posedge clk) begin
    if (rst_i) begin
      w_beats <= '0;
    end else if (wvalid_i && wready_i) begin
      w_beats <= wlast_i ? 8'd0 : w_beats + 8'd1;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (rst_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else $error("awvalid dropped before awready");

  w_hold: assert property (@(posedge clk) disable iff (rst_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else $error("wvalid dropped before wready");

  aw_stable: assert property (@(posedge clk) disable iff (rst_i)
    awvalid_i && !awready_i |=> $stable(aw_i))
    else $error("aw command changed while waiting");

  // wlast only with wvalid, on the beat that awlen names
  wlast_valid: assert property (@(posedge clk) disable iff (rst_i)
    wlast_i |-> wvalid_i && (w_beats == aw_i.len))
    else $error("wlast without wvalid or off the last beat");

endmodule

bind bridge_write_engine bridge_assertions i_assert (
  .clk       (clk),
  .rst_i     (mw_addr_finish_rst),
  .awvalid_i (m_awvalid_o),
  .awready_i (m_awready_i),
  .wvalid_i  (m_wvalid_o),
  .wready_i  (m_wready_i),
  .wlast_i   (m_wlast_o),
  .aw_i      (m_aw_o)
);

/* test/axi_mem_model.sv */
module axi_mem_model (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [3:0]  arid_i,
  input  logic [31:0] araddr_i,
  input  logic [7:0]  arlen_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [3:0]  rid_o,
  output logic [31:0] rdata_o,
  output logic        rlast_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        wlast_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic        bvalid_o,
  input  logic        bready_i
);

  logic [31:0] mem [0:255];
  integer      seed = 78897;
  logic        rd_active;
  logic [7:0]  rd_idx;
  logic [7:0]  rd_left;   // beats after the current one
  logic [3:0]  rd_id;
  logic        wr_addr_ok;
  logic        w_finished;
  logic [7:0]  wr_idx;
  logic        r_hold;
  logic        b_hold;

  // random stall decision
  function automatic logic coin();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h01010101) ^ 32'hc35a0000;  // whole word index
    end
    arready_o  = 1'b0;
    rvalid_o   = 1'b0;
    rid_o      = '0;
    rdata_o    = '0;
    rlast_o    = 1'b0;
    awready_o  = 1'b0;
    wready_o   = 1'b0;
    bvalid_o   = 1'b0;
    rd_active  = 1'b0;
    rd_idx     = '0;
    rd_left    = '0;
    rd_id      = '0;
    wr_addr_ok = 1'b0;
    w_finished = 1'b0;
    wr_idx     = '0;
    forever begin
      @(posedge clk);
      r_hold = rvalid_o && !rready_i;  // beat not taken yet
      b_hold = bvalid_o && !bready_i;
      if (rst_i) begin
        rd_active  = 1'b0;
        wr_addr_ok = 1'b0;
        w_finished = 1'b0;
        r_hold     = 1'b0;
        b_hold     = 1'b0;
      end else begin
        if (arvalid_i && arready_o) begin
          rd_active = 1'b1;
          rd_idx    = araddr_i[9:2];
          rd_left   = arlen_i;
          rd_id     = arid_i;
        end else if (rvalid_o && rready_i) begin
          if (rd_left == 8'd0) begin
            rd_active = 1'b0;
          end else begin
            rd_idx  = rd_idx + 8'd1;
            rd_left = rd_left - 8'd1;
          end
        end
        if (awvalid_i && awready_o) begin
          wr_addr_ok = 1'b1;
          wr_idx     = awaddr_i[9:2];
        end
        if (wvalid_i && wready_o) begin
          for (int b = 0; b < 4; b++) begin
            if (wstrb_i[b]) begin
              mem[wr_idx][8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          wr_idx = wr_idx + 8'd1;
          if (wlast_i) begin
            w_finished = 1'b1;
          end
        end
        if (bvalid_o && bready_i) begin
          wr_addr_ok = 1'b0;
          w_finished = 1'b0;
        end
      end
      #1;
      arready_o = !rst_i && !rd_active && coin();
      rvalid_o  = rd_active && (r_hold || coin());
      rid_o     = rd_id;
      rdata_o   = mem[rd_idx];
      rlast_o   = (rd_left == 8'd0);
      awready_o = !rst_i && !wr_addr_ok && coin();
      wready_o  = wr_addr_ok && !w_finished && coin();  // W only after AW
      bvalid_o  = w_finished && (b_hold || coin());
    end
  end

endmodule

/* test/tb_sram_axi_bridge.sv */
module tb_sram_axi_bridge;

  localparam int N_TESTS = 6;
  localparam logic [3:0] INST_ID = 4'd0;
  localparam logic [3:0] DATA_ID = 4'd1;

  logic                  clk;
  logic                  mw_addr_finish_rst;
  bridge_pkg::rd_req_t   inst_req;
  bridge_pkg::rd_req_t   data_req;
  bridge_pkg::wr_req_t   data_wr;
  bridge_pkg::port_rsp_t inst_rsp;
  bridge_pkg::port_rsp_t data_rsp;
  logic [3:0]  arid;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic        arvalid;
  logic        arready;
  logic [3:0]  rid;
  logic [31:0] rdata;
  logic        rlast;
  logic        rvalid;
  logic        rready;
  logic [31:0] awaddr;
  logic [7:0]  awlen;
  logic [2:0]  awsize;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;

  logic [31:0] shadow [0:255];
  logic [32:0] exp_inst[$];  // {rlast, rdata}
  logic [32:0] exp_data[$];
  int          errors = 0;
  int          checks = 0;

  sram_axi_bridge #(.INST_ARID(INST_ID), .DATA_ARID(DATA_ID)) i_dut (
    .clk(clk), .mw_addr_finish_rst(mw_addr_finish_rst),
    .inst_req_i(inst_req), .data_req_i(data_req), .data_wr_i(data_wr),
    .inst_rsp_o(inst_rsp), .data_rsp_o(data_rsp),
    .m_arid_o(arid), .m_araddr_o(araddr), .m_arlen_o(arlen), .m_arsize_o(arsize),
    .m_arvalid_o(arvalid), .m_arready_i(arready), .m_rid_i(rid), .m_rdata_i(rdata),
    .m_rlast_i(rlast), .m_rvalid_i(rvalid), .m_rready_o(rready),
    .m_awaddr_o(awaddr), .m_awlen_o(awlen), .m_awsize_o(awsize),
    .m_awvalid_o(awvalid), .m_awready_i(awready), .m_wdata_o(wdata),
    .m_wstrb_o(wstrb), .m_wlast_o(wlast), .m_wvalid_o(wvalid), .m_wready_i(wready),
    .m_bvalid_i(bvalid), .m_bready_o(bready)
  );

  axi_mem_model i_mem (
    .clk(clk), .rst_i(mw_addr_finish_rst),
    .arid_i(arid), .araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid),
    .arready_o(arready), .rid_o(rid), .rdata_o(rdata), .rlast_o(rlast),
    .rvalid_o(rvalid), .rready_i(rready), .awaddr_i(awaddr), .awvalid_i(awvalid),
    .awready_o(awready), .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast),
    .wvalid_i(wvalid), .wready_o(wready), .bvalid_o(bvalid), .bready_i(bready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // expected read word from the shadow memory
  function automatic logic [31:0] ref_word(input logic [7:0] idx);
    return shadow[idx];
  endfunction

  function automatic logic [7:0] exp_len(input bridge_pkg::access_e acc);
    return (acc == bridge_pkg::ACC_LINE) ? 8'd3 : 8'd0;
  endfunction

  function automatic logic [2:0] exp_size(input bridge_pkg::access_e acc);
    case (acc)
      bridge_pkg::ACC_BYTE: return 3'd0;
      bridge_pkg::ACC_HALF: return 3'd1;
      default:              return 3'd2;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_idle_outputs();
    compare_value("m_arvalid", 32'(arvalid), 32'h0);
    compare_value("m_awvalid", 32'(awvalid), 32'h0);
    compare_value("m_wvalid", 32'(wvalid), 32'h0);
    compare_value("m_rready", 32'(rready), 32'h0);
    compare_value("m_bready", 32'(bready), 32'h0);
    compare_value("inst_rsp.rvalid", 32'(inst_rsp.rvalid), 32'h0);
    compare_value("inst_rsp.rlast", 32'(inst_rsp.rlast), 32'h0);
    compare_value("inst_rsp.wready", 32'(inst_rsp.wready), 32'h0);
    compare_value("data_rsp.rvalid", 32'(data_rsp.rvalid), 32'h0);
    compare_value("data_rsp.rlast", 32'(data_rsp.rlast), 32'h0);
  endtask

  task automatic issue_read(input logic to_data, input bridge_pkg::access_e acc,
                            input logic [31:0] addr);
    int         beats;
    logic [7:0] idx;
    beats = (acc == bridge_pkg::ACC_LINE) ? 4 : 1;
    @(posedge clk);
    #1;
    for (int i = 0; i < beats; i++) begin
      idx = addr[9:2] + 8'(i);
      if (to_data) exp_data.push_back({(i == beats - 1), ref_word(idx)});
      else exp_inst.push_back({(i == beats - 1), ref_word(idx)});
    end
    if (to_data) begin
      data_req = '{req: 1'b1, rtype: acc, addr: addr};
    end else begin
      inst_req = '{req: 1'b1, rtype: acc, addr: addr};
    end
    do @(negedge clk); while (to_data ? !data_rsp.rready : !inst_rsp.rready);
    @(posedge clk);
    #1;
    if (to_data) data_req.req = 1'b0;
    else inst_req.req = 1'b0;
    @(negedge clk);  // AR is up one cycle after acceptance
    compare_value("m_arvalid", 32'(arvalid), 32'h1);
    compare_value("m_arid", 32'(arid), 32'(to_data ? DATA_ID : INST_ID));
    compare_value("m_araddr", araddr, addr);
    compare_value("m_arlen", 32'(arlen), 32'(exp_len(acc)));
    compare_value("m_arsize", 32'(arsize), 32'(exp_size(acc)));
  endtask

  task automatic issue_write(input bridge_pkg::access_e acc, input logic [31:0] addr,
                             input logic [3:0] strb, input logic [127:0] line);
    int         beats;
    logic [7:0] idx;
    beats = (acc == bridge_pkg::ACC_LINE) ? 4 : 1;
    @(posedge clk);
    #1;
    data_wr = '{wr: 1'b1, wtype: acc, addr: addr, wstrb: strb, wdata: line};
    do @(negedge clk); while (!data_rsp.wready);
    @(posedge clk);
    #1;
    data_wr.wr = 1'b0;
    for (int b = 0; b < beats; b++) begin
      idx = addr[9:2] + 8'(b);
      for (int k = 0; k < 4; k++) begin
        if (strb[k]) shadow[idx][8*k +: 8] = line[32*b + 8*k +: 8];
      end
    end
    @(negedge clk);  // AW and W are up one cycle after acceptance
    compare_value("m_awvalid", 32'(awvalid), 32'h1);
    compare_value("m_wvalid", 32'(wvalid), 32'h1);
    compare_value("m_awaddr", awaddr, addr);
    compare_value("m_awlen", 32'(awlen), 32'(exp_len(acc)));
    compare_value("m_awsize", 32'(awsize), 32'(exp_size(acc)));
    do @(negedge clk); while (!data_rsp.wready);  // write finished
  endtask

  task automatic wait_reads_done();
    while (exp_inst.size() != 0 || exp_data.size() != 0) @(posedge clk);
  endtask

  // compare every returned beat against the expected queues
  initial begin
    logic [32:0] e;
    forever begin
      @(negedge clk);
      if (inst_rsp.rvalid) begin
        if (exp_inst.size() == 0) begin
          errors++;
          $display("port 1 returned a beat that was never requested");
        end else begin
          e = exp_inst.pop_front();
          compare_value("inst_rsp.rdata", inst_rsp.rdata, e[31:0]);
          compare_value("inst_rsp.rlast", 32'(inst_rsp.rlast), 32'(e[32]));
        end
      end
      if (data_rsp.rvalid) begin
        if (exp_data.size() == 0) begin
          errors++;
          $display("port 2 returned a beat that was never requested");
        end else begin
          e = exp_data.pop_front();
          compare_value("data_rsp.rdata", data_rsp.rdata, e[31:0]);
          compare_value("data_rsp.rlast", 32'(data_rsp.rlast), 32'(e[32]));
        end
      end
    end
  end

  initial begin
    #(N_TESTS * 200 * 8);
    $display("timeout: the run did not finish within %0d cycles", N_TESTS * 200);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    for (int i = 0; i < 256; i++) begin
      shadow[i] = (32'(i) * 32'h01010101) ^ 32'hc35a0000;
    end
    mw_addr_finish_rst = 1'b1;
    inst_req = '0;
    data_req = '0;
    data_wr  = '0;
    repeat (8) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #1 mw_addr_finish_rst = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs();
    end
    issue_read(1'b0, bridge_pkg::ACC_WORD, 32'h40);
    wait_reads_done();
    issue_read(1'b1, bridge_pkg::ACC_LINE, 32'h80);
    wait_reads_done();
    issue_write(bridge_pkg::ACC_WORD, 32'h44, 4'b0101, {96'h0, 32'hdeadbeef});
    issue_read(1'b1, bridge_pkg::ACC_WORD, 32'h44);
    wait_reads_done();
    issue_write(bridge_pkg::ACC_LINE, 32'hc0, 4'hf,
                128'h44444444_33333333_22222222_11111111);
    issue_read(1'b1, bridge_pkg::ACC_LINE, 32'hc0);
    wait_reads_done();
    // both ports in the same cycle, data goes first
    fork
      issue_read(1'b0, bridge_pkg::ACC_WORD, 32'h10);
      issue_read(1'b1, bridge_pkg::ACC_LINE, 32'h20);
      begin
        @(posedge clk);
        #1;
        @(negedge clk);
        compare_value("inst_rsp.rready", 32'(inst_rsp.rready), 32'h0);
        compare_value("data_rsp.rready", 32'(data_rsp.rready), 32'h1);
      end
    join
    wait_reads_done();
    repeat (4) @(posedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
source/bridge_pkg.sv
source/bridge_req_decode.sv
source/bridge_read_engine.sv
source/bridge_write_engine.sv
source/sram_axi_bridge.sv
test/bridge_assertions.sv
test/axi_mem_model.sv
test/tb_sram_axi_bridge.sv

/* Makefile */
TOP = tb_sram_axi_bridge

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
